// File: design/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Integer data width of the core
`define RV_XLEN 32

// Architectural register index width
`define RV_REG_W 5

// Shift amount width, low bits of operand b
`define RV_SHAMT_W 5

// Fetch restarts here out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: design/rv_core_pkg.sv
`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0]  data_t;
  typedef logic [`RV_XLEN-1:0]  addr_t;
  typedef logic [`RV_REG_W-1:0] reg_idx_t;

  typedef enum logic [3:0] {
    ALU_OP__ADD  = 4'd0,
    ALU_OP__SUB  = 4'd1,
    ALU_OP__AND  = 4'd2,
    ALU_OP__OR   = 4'd3,
    ALU_OP__XOR  = 4'd4,
    ALU_OP__SLL  = 4'd5,
    ALU_OP__SRL  = 4'd6,
    ALU_OP__SRA  = 4'd7,
    ALU_OP__SLT  = 4'd8,
    ALU_OP__SLTU = 4'd9
  } alu_op_t;

  typedef enum logic {
    ALU_SRC_B__RD2     = 1'b0,
    ALU_SRC_B__IMM_EXT = 1'b1
  } alu_src_b_t;

  // Writeback source for the instruction
  typedef enum logic [1:0] {
    RESULT_SRC__ALU = 2'd0,
    RESULT_SRC__MEM = 2'd1,
    RESULT_SRC__PC4 = 2'd2
  } result_src_t;

  typedef enum logic [1:0] {
    PC_SRC__INCREMENT = 2'd0,
    PC_SRC__BRANCH    = 2'd1,
    PC_SRC__JAL       = 2'd2,
    PC_SRC__JALR      = 2'd3
  } pc_src_t;

  // Branch condition encodings in funct3
  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  // Decoded instruction from the decode stage
  typedef struct packed {
    logic        valid;
    addr_t       pc_cur;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    data_t       rd1;
    data_t       rd2;
    data_t       imm_ext;
    reg_idx_t    rd;
    logic [2:0]  funct3;
    alu_op_t     alu_control;
    alu_src_b_t  alu_src_b;
    result_src_t result_src;
    logic        reg_write;
    pc_src_t     pc_src;
  } id_to_ex_t;

  // Record handed to the memory stage
  typedef struct packed {
    logic        valid;
    result_src_t result_src;
    logic        reg_write;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    data_t       alu_result;
    data_t       rd2;
    addr_t       pc_cur;
  } ex_to_mem_t;

  // Fetch redirect
  typedef struct packed {
    logic  redirect;
    addr_t target;
  } ex_to_if_t;

endpackage

`default_nettype wire

// File: design/alu.sv
`default_nettype none

`include "rv_core_cfg.svh"

module alu
  ( input  rv_core_pkg::data_t   a
  , input  rv_core_pkg::data_t   b
  , input  rv_core_pkg::alu_op_t op
  , output rv_core_pkg::data_t   result
  , output logic                 zero
  , output logic                 lt
  , output logic                 ltu
  );

  import rv_core_pkg::*;

  logic [`RV_SHAMT_W-1:0] shamt;

  assign shamt = b[`RV_SHAMT_W-1:0];

  // Compare flags come straight from the operands, so branches reuse them
  assign lt  = $signed(a) < $signed(b);
  assign ltu = a < b;

  always_comb begin
    case (op)
      ALU_OP__ADD:  result = a + b;
      ALU_OP__SUB:  result = a - b;
      ALU_OP__AND:  result = a & b;
      ALU_OP__OR:   result = a | b;
      ALU_OP__XOR:  result = a ^ b;
      ALU_OP__SLL:  result = a << shamt;
      ALU_OP__SRL:  result = a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_OP__SRA:  result = data_t'($signed(a) >>> shamt);
      ALU_OP__SLT:  result = data_t'(lt);
      ALU_OP__SLTU: result = data_t'(ltu);
      default:      result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/branch_unit.sv
`default_nettype none

module branch_unit
  ( input  logic                 valid
  , input  rv_core_pkg::pc_src_t pc_src
  , input  logic [2:0]           funct3
  , input  rv_core_pkg::addr_t   pc_cur
  , input  rv_core_pkg::data_t   imm_ext
  , input  rv_core_pkg::data_t   alu_result
  , input  logic                 zero
  , input  logic                 lt
  , input  logic                 ltu
  , output logic                 redirect
  , output rv_core_pkg::addr_t   target
  );

  import rv_core_pkg::*;

  logic  cond_true;
  addr_t pc_rel;
  addr_t jalr_addr;

  assign pc_rel    = pc_cur + imm_ext;
  // JALR drops bit 0 of the computed address
  assign jalr_addr = {alu_result[$bits(addr_t)-1:1], 1'b0};

  // Condition evaluated on the flags of the SUB
  always_comb begin
    case (funct3)
      FUNCT3_BEQ:  cond_true = zero;
      FUNCT3_BNE:  cond_true = !zero;
      FUNCT3_BLT:  cond_true = lt;
      FUNCT3_BGE:  cond_true = !lt;
      FUNCT3_BLTU: cond_true = ltu;
      FUNCT3_BGEU: cond_true = !ltu;
      default:     cond_true = 1'b0;
    endcase
  end

  always_comb begin
    redirect = 1'b0;
    if (valid) begin
      case (pc_src)
        PC_SRC__BRANCH: redirect = cond_true;
        PC_SRC__JAL:    redirect = 1'b1;
        PC_SRC__JALR:   redirect = 1'b1;
        default:        redirect = 1'b0;
      endcase
    end
  end

  assign target = (pc_src == PC_SRC__JALR) ? jalr_addr : pc_rel;

endmodule

`default_nettype wire

// File: design/forward_unit.sv
`default_nettype none

module forward_unit
  ( input  rv_core_pkg::reg_idx_t   rs1
  , input  rv_core_pkg::reg_idx_t   rs2
  , input  rv_core_pkg::data_t      rd1
  , input  rv_core_pkg::data_t      rd2
  , input  rv_core_pkg::ex_to_mem_t mem_fwd
  , output rv_core_pkg::data_t      op_a
  , output rv_core_pkg::data_t      op_b_reg
  );

  import rv_core_pkg::*;

  logic producer_ok;
  logic fwd_a;
  logic fwd_b;

  // Only a valid ALU result headed for a real register can be forwarded
  assign producer_ok = mem_fwd.valid
                    && mem_fwd.reg_write
                    && (mem_fwd.result_src == RESULT_SRC__ALU)
                    && (mem_fwd.rd != '0);

  assign fwd_a = producer_ok && (mem_fwd.rd == rs1);
  assign fwd_b = producer_ok && (mem_fwd.rd == rs2);

  assign op_a     = fwd_a ? mem_fwd.alu_result : rd1;
  // Also the store data, so it is taken before the immediate mux
  assign op_b_reg = fwd_b ? mem_fwd.alu_result : rd2;

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`default_nettype none

`include "rv_core_cfg.svh"

module execute_stage
  ( input  logic                    clk
  , input  logic                    reset
  , input  rv_core_pkg::id_to_ex_t  id_to_ex
  , output rv_core_pkg::ex_to_mem_t ex_to_mem
  , output rv_core_pkg::ex_to_if_t  ex_to_if
  );

  import rv_core_pkg::*;

  data_t      op_a;
  data_t      op_b_reg;
  data_t      op_b;
  data_t      alu_result;
  logic       zero;
  logic       lt;
  logic       ltu;
  logic       redirect;
  addr_t      target;
  ex_to_mem_t mem_next;

  // Previous instruction's record feeds back for forwarding
  forward_unit forward_unit_inst
    ( .rs1      ( id_to_ex.rs1 )
    , .rs2      ( id_to_ex.rs2 )
    , .rd1      ( id_to_ex.rd1 )
    , .rd2      ( id_to_ex.rd2 )
    , .mem_fwd  ( ex_to_mem    )
    , .op_a     ( op_a         )
    , .op_b_reg ( op_b_reg     )
    );

  always_comb begin
    case (id_to_ex.alu_src_b)
      ALU_SRC_B__IMM_EXT: op_b = id_to_ex.imm_ext;
      default:            op_b = op_b_reg;
    endcase
  end

  alu alu_inst
    ( .a      ( op_a                 )
    , .b      ( op_b                 )
    , .op     ( id_to_ex.alu_control )
    , .result ( alu_result           )
    , .zero   ( zero                 )
    , .lt     ( lt                   )
    , .ltu    ( ltu                  )
    );

  branch_unit branch_unit_inst
    ( .valid      ( id_to_ex.valid   )
    , .pc_src     ( id_to_ex.pc_src  )
    , .funct3     ( id_to_ex.funct3  )
    , .pc_cur     ( id_to_ex.pc_cur  )
    , .imm_ext    ( id_to_ex.imm_ext )
    , .alu_result ( alu_result       )
    , .zero       ( zero             )
    , .lt         ( lt               )
    , .ltu        ( ltu              )
    , .redirect   ( redirect         )
    , .target     ( target           )
    );

  always_comb begin
    mem_next.valid      = id_to_ex.valid;
    mem_next.result_src = id_to_ex.result_src;
    mem_next.reg_write  = id_to_ex.reg_write;
    mem_next.funct3     = id_to_ex.funct3;
    mem_next.rd         = id_to_ex.rd;
    mem_next.alu_result = alu_result;
    // Store data after forwarding
    mem_next.rd2        = op_b_reg;
    mem_next.pc_cur     = id_to_ex.pc_cur;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_to_mem          <= '0;
      ex_to_if.redirect  <= 1'b0;
      ex_to_if.target    <= `RV_RESET_PC;
    end else begin
      ex_to_mem          <= mem_next;
      ex_to_if.redirect  <= redirect;
      ex_to_if.target    <= target;
    end
  end

endmodule

`default_nettype wire

// File: design/ex_top.sv
`default_nettype none

module ex_top
  ( input  logic                    clk
  , input  logic                    reset
  , input  rv_core_pkg::id_to_ex_t  id_to_ex
  , output rv_core_pkg::ex_to_mem_t ex_to_mem
  , output rv_core_pkg::ex_to_if_t  ex_to_if
  );

  rv_core_pkg::ex_to_mem_t ex_to_mem_w;
  rv_core_pkg::ex_to_if_t  ex_to_if_w;

  // Single execute stage, one cycle from strobe to records
  execute_stage execute_stage_inst
    ( .clk       ( clk         )
    , .reset     ( reset       )
    , .id_to_ex  ( id_to_ex    )
    , .ex_to_mem ( ex_to_mem_w )
    , .ex_to_if  ( ex_to_if_w  )
    );

  assign ex_to_mem = ex_to_mem_w;
  assign ex_to_if  = ex_to_if_w;

endmodule

`default_nettype wire

// File: dv/ex_top_props.sv
`default_nettype none

module ex_top_props
  ( input logic                    clk
  , input logic                    reset
  , input rv_core_pkg::id_to_ex_t  id_to_ex
  , input rv_core_pkg::ex_to_mem_t ex_to_mem
  , input rv_core_pkg::ex_to_if_t  ex_to_if
  );

  timeunit 1ns;
  timeprecision 1ps;

  import rv_core_pkg::*;

  // A bubble never turns into a fetch redirect
  redirect_needs_valid: assert property (
    @(posedge clk) disable iff (reset) !id_to_ex.valid |=> !ex_to_if.redirect
  ) else $error("redirect raised one cycle after an invalid instruction");

  outputs_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(ex_to_mem) && !$isunknown(ex_to_if)
  ) else $error("unknown bits on the stage outputs after reset");

  // JALR targets are always halfword aligned
  jalr_target_even: assert property (
    @(posedge clk) disable iff (reset)
      (id_to_ex.valid && id_to_ex.pc_src == PC_SRC__JALR) |=> !ex_to_if.target[0]
  ) else $error("JALR target has bit 0 set");

endmodule

bind ex_top ex_top_props ex_top_props_inst
  ( .clk       ( clk       )
  , .reset     ( reset     )
  , .id_to_ex  ( id_to_ex  )
  , .ex_to_mem ( ex_to_mem )
  , .ex_to_if  ( ex_to_if  )
  );

`default_nettype wire

// File: dv/tb_ex_top.sv
`default_nettype none

`include "rv_core_cfg.svh"

module tb_ex_top;

  timeunit 1ns;
  timeprecision 1ps;

  import rv_core_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int N_RAND     = 64;
  // Reset, ALU, forwarding, branch, jump and random cycles, plus one bubble per test
  localparam int TOTAL_CYCLES = 4 + 20 + 27 + 24 + 8 + N_RAND + 5;
  localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 40) * CLK_PERIOD;

  typedef struct packed {
    logic [31:0] due;
    ex_to_mem_t  mem;
    ex_to_if_t   ifr;
  } expect_t;

  logic        clk;
  logic        reset;
  id_to_ex_t   id_to_ex;
  ex_to_mem_t  ex_to_mem;
  ex_to_if_t   ex_to_if;
  logic [31:0] rng_state;
  int          cycle_cnt;
  int          errors;
  int          checks;
  int          test_start_err;
  string       cur_test;
  ex_to_mem_t  model_prev;
  reg_idx_t    last_rd;
  expect_t     exp_q[$];

  ex_top ex_top_inst
    ( .clk       ( clk       )
    , .reset     ( reset     )
    , .id_to_ex  ( id_to_ex  )
    , .ex_to_mem ( ex_to_mem )
    , .ex_to_if  ( ex_to_if  )
    );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic data_t ref_alu(input data_t a, input data_t b, input alu_op_t op);
    logic [4:0] sh;
    logic       slt;
    sh  = b[4:0];
    // Signs differ, so the negative one is smaller
    slt = (a[31] != b[31]) ? a[31] : (a < b);
    case (op)
      ALU_OP__ADD:  return a + b;
      ALU_OP__SUB:  return a - b;
      ALU_OP__AND:  return a & b;
      ALU_OP__OR:   return a | b;
      ALU_OP__XOR:  return a ^ b;
      ALU_OP__SLL:  return a << sh;
      ALU_OP__SRL:  return a >> sh;
      ALU_OP__SRA:  return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
      ALU_OP__SLT:  return {31'b0, slt};
      ALU_OP__SLTU: return {31'b0, a < b};
      default:      return '0;
    endcase
  endfunction

  function automatic void compute_expected(input id_to_ex_t ins, input ex_to_mem_t prev,
                                           output ex_to_mem_t m, output ex_to_if_t f);
    logic  fwd_ok;
    data_t a;
    data_t b_reg;
    data_t b;
    data_t res;
    logic  lt_s;
    logic  lt_u;
    logic  take;
    fwd_ok = prev.valid && prev.reg_write && (prev.result_src == RESULT_SRC__ALU)
             && (prev.rd != 0);
    a      = (fwd_ok && prev.rd == ins.rs1) ? prev.alu_result : ins.rd1;
    b_reg  = (fwd_ok && prev.rd == ins.rs2) ? prev.alu_result : ins.rd2;
    b      = (ins.alu_src_b == ALU_SRC_B__IMM_EXT) ? ins.imm_ext : b_reg;
    res    = ref_alu(a, b, ins.alu_control);
    lt_s   = (ref_alu(a, b, ALU_OP__SLT) != 0);
    lt_u   = (ref_alu(a, b, ALU_OP__SLTU) != 0);
    case (ins.funct3)
      FUNCT3_BEQ:  take = (res == 0);
      FUNCT3_BNE:  take = (res != 0);
      FUNCT3_BLT:  take = lt_s;
      FUNCT3_BGE:  take = !lt_s;
      FUNCT3_BLTU: take = lt_u;
      FUNCT3_BGEU: take = !lt_u;
      default:     take = 1'b0;
    endcase
    m.valid      = ins.valid;
    m.result_src = ins.result_src;
    m.reg_write  = ins.reg_write;
    m.funct3     = ins.funct3;
    m.rd         = ins.rd;
    m.alu_result = res;
    m.rd2        = b_reg;
    m.pc_cur     = ins.pc_cur;
    f.redirect   = ins.valid && ((ins.pc_src == PC_SRC__JAL) || (ins.pc_src == PC_SRC__JALR)
                   || ((ins.pc_src == PC_SRC__BRANCH) && take));
    f.target     = (ins.pc_src == PC_SRC__JALR) ? (res & ~32'd1) : ins.pc_cur + ins.imm_ext;
  endfunction

  function automatic id_to_ex_t rand_instr();
    id_to_ex_t   ins;
    logic [31:0] r;
    logic [31:0] imm;
    r   = next_rand();
    imm = next_rand();
    ins.valid       = 1'b1;
    ins.pc_cur      = next_rand() & 32'hffff_fffc;
    // Half the sources hit the last destination
    ins.rs1         = r[0] ? last_rd : reg_idx_t'(r[8:4]);
    ins.rs2         = r[1] ? last_rd : reg_idx_t'(r[13:9]);
    ins.rd1         = next_rand();
    ins.rd2         = next_rand();
    ins.imm_ext     = {{20{imm[11]}}, imm[11:0]};
    ins.rd          = r[18:14];
    ins.funct3      = r[21:19];
    ins.alu_control = alu_op_t'(r[25:22] % 4'd10);
    ins.alu_src_b   = alu_src_b_t'(r[26]);
    ins.result_src  = r[27] ? RESULT_SRC__MEM : RESULT_SRC__ALU;
    ins.reg_write   = r[28] | r[29];
    ins.pc_src      = PC_SRC__INCREMENT;
    return ins;
  endfunction

  task automatic issue(input id_to_ex_t ins);
    ex_to_mem_t m;
    ex_to_if_t  f;
    expect_t    e;
    @(negedge clk);
    id_to_ex = ins;
    compute_expected(ins, model_prev, m, f);
    model_prev = m;
    if (ins.valid)
      last_rd = ins.rd;
    e.due = cycle_cnt + 1;
    e.mem = m;
    e.ifr = f;
    exp_q.push_back(e);
    checks++;
  endtask

  // Idle the input, then let every pending result be checked
  task automatic end_test();
    issue('0);
    while (exp_q.size() != 0)
      @(negedge clk);
    $display("test %s done: %0d errors", cur_test, errors - test_start_err);
  endtask

  always @(negedge clk) begin
    expect_t e;
    if (exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
      e = exp_q[0];
      if (e.mem.valid) begin
        assert (ex_to_mem == e.mem) else begin
          $display("mismatch %s ex_to_mem: expected %h actual %h", cur_test, e.mem, ex_to_mem);
          errors++;
        end
      end else begin
        assert (!ex_to_mem.valid) else begin
          $display("mismatch %s valid: expected 0 actual %b", cur_test, ex_to_mem.valid);
          errors++;
        end
      end
      assert (ex_to_if.redirect == e.ifr.redirect) else begin
        $display("mismatch %s redirect: expected %b actual %b", cur_test,
                 e.ifr.redirect, ex_to_if.redirect);
        errors++;
      end
      if (e.ifr.redirect) begin
        assert (ex_to_if.target == e.ifr.target) else begin
          $display("mismatch %s target: expected %h actual %h", cur_test,
                   e.ifr.target, ex_to_if.target);
          errors++;
        end
      end
      exp_q.pop_front();
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    id_to_ex_t   ins;
    id_to_ex_t   prod;
    id_to_ex_t   bub;
    logic [31:0] r;
    rng_state  = 32'h1c47;
    reset      = 1'b1;
    id_to_ex   = '0;
    model_prev = '0;
    last_rd    = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    cur_test       = "reset";
    test_start_err = errors;
    checks        += 2;
    assert (ex_to_mem == '0) else begin
      $display("mismatch reset ex_to_mem: expected %h actual %h", '0, ex_to_mem);
      errors++;
    end
    assert (ex_to_if == {1'b0, `RV_RESET_PC}) else begin
      $display("mismatch reset ex_to_if: expected %h actual %h", {1'b0, `RV_RESET_PC}, ex_to_if);
      errors++;
    end
    $display("test %s done: %0d errors", cur_test, errors - test_start_err);

    cur_test       = "alu_ops";
    test_start_err = errors;
    for (int op = 0; op < 10; op++) begin
      for (int src = 0; src < 2; src++) begin
        ins             = rand_instr();
        ins.alu_control = alu_op_t'(op);
        ins.alu_src_b   = alu_src_b_t'(src);
        issue(ins);
      end
    end
    end_test();

    // Direct, bubble between, rd zero, load producer
    cur_test       = "forwarding";
    test_start_err = errors;
    for (int rep = 0; rep < 3; rep++) begin
      for (int kind = 0; kind < 4; kind++) begin
        prod            = rand_instr();
        prod.rd         = reg_idx_t'(rep * 4 + kind + 1);
        prod.reg_write  = 1'b1;
        prod.result_src = (kind == 3) ? RESULT_SRC__MEM : RESULT_SRC__ALU;
        if (kind == 2)
          prod.rd = '0;
        issue(prod);
        // Bubble still names the producer's destination
        if (kind == 1) begin
          bub       = prod;
          bub.valid = 1'b0;
          issue(bub);
        end
        ins           = rand_instr();
        ins.rs1       = prod.rd;
        ins.rs2       = prod.rd;
        ins.alu_src_b = ALU_SRC_B__RD2;
        issue(ins);
      end
    end
    end_test();

    cur_test       = "branches";
    test_start_err = errors;
    for (int c = 0; c < 6; c++) begin
      for (int k = 0; k < 4; k++) begin
        ins             = rand_instr();
        ins.funct3      = (c < 2) ? 3'(c) : 3'(c + 2);
        ins.pc_src      = PC_SRC__BRANCH;
        ins.alu_control = ALU_OP__SUB;
        ins.alu_src_b   = ALU_SRC_B__RD2;
        ins.reg_write   = 1'b0;
        if (k == 1)
          ins.rd2 = ins.rd1;
        else if (k == 2)
          ins.rd2 = ~ins.rd1;
        issue(ins);
      end
    end
    end_test();

    cur_test       = "jumps";
    test_start_err = errors;
    for (int k = 0; k < 8; k++) begin
      ins             = rand_instr();
      ins.pc_src      = k[0] ? PC_SRC__JALR : PC_SRC__JAL;
      ins.alu_control = ALU_OP__ADD;
      ins.alu_src_b   = ALU_SRC_B__IMM_EXT;
      ins.result_src  = RESULT_SRC__PC4;
      ins.reg_write   = 1'b1;
      // Odd sums make JALR drop bit 0
      ins.rd1[0]      = 1'b0;
      ins.imm_ext[0]  = k[1];
      issue(ins);
    end
    end_test();

    cur_test       = "random";
    test_start_err = errors;
    for (int k = 0; k < N_RAND; k++) begin
      ins        = rand_instr();
      r          = next_rand();
      ins.valid  = (r[1:0] != 2'b00);
      ins.pc_src = pc_src_t'(r[3:2]);
      if (ins.pc_src == PC_SRC__BRANCH) begin
        ins.alu_control = ALU_OP__SUB;
        ins.alu_src_b   = ALU_SRC_B__RD2;
      end
      issue(ins);
    end
    end_test();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/rv_core_pkg.sv
design/alu.sv
design/branch_unit.sv
design/forward_unit.sv
design/execute_stage.sv
design/ex_top.sv
dv/ex_top_props.sv
dv/tb_ex_top.sv

// File: Bender.yml
package:
  name: rv_ex_stage

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rv_core_pkg.sv
      - design/alu.sv
      - design/branch_unit.sv
      - design/forward_unit.sv
      - design/execute_stage.sv
      - design/ex_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - dv/ex_top_props.sv
      - dv/tb_ex_top.sv
